// File: verilog/usbRxPkg.sv
package usbRxPkg;

    // full-speed line rate is 12 Mbit/s, sampled at 48 MHz
    localparam logic [7:0] ClksPerBit = 8'd4;

    // KJKJKJKK after NRZI decoding, seven zeros and a closing one received LSB first
    localparam logic [7:0] SyncPattern = 8'h80;

    // remainders left in the shift register once the inverted CRC has been shifted in
    localparam logic [4:0]  Crc5Residue  = 5'b01100;
    localparam logic [15:0] Crc16Residue = 16'h800D;

    localparam logic [7:0] FifoDepth = 8'd4;  // bytes buffered towards the backend

    typedef enum logic [3:0] {
        PidOut   = 4'b0001,
        PidIn    = 4'b1001,
        PidSof   = 4'b0101,
        PidSetup = 4'b1101,
        PidData0 = 4'b0011,
        PidData1 = 4'b1011,
        PidAck   = 4'b0010,
        PidNak   = 4'b1010,
        PidStall = 4'b1110
    } pidCode_e;

    // the upper nibble repeats the code inverted so a damaged PID can be spotted
    typedef struct packed {
        logic [3:0] check;
        pidCode_e   code;
    } pidFields_t;

    typedef union packed {
        logic [7:0] raw;     // byte as it comes off the wire
        pidFields_t fields;  // same byte split into check and code
    } pidByte_u;

endpackage

// File: verilog/usbSerialFrontend.sv
`timescale 1ns/1ps

module usbSerialFrontend (
    input  logic clk48_i,
    input  logic reset_i,
    input  logic usbDp_i,
    input  logic usbDn_i,
    output logic dataP_o,
    output logic dataEdge_o,
    output logic isValidDp_o,
    output logic eopDetected_o,
    input  logic ackEop_i
);

    logic [1:0] dpSync;     // [1] is the metastability-safe copy of D+
    logic [1:0] dnSync;
    logic [1:0] lineState;  // {D+, D-} as seen after synchronisation
    logic [1:0] prevState;
    logic [7:0] se0Count;   // cycles the line has spent in SE0 so far
    logic [7:0] eopLimit;
    logic       se0;
    logic       eopFlag;

    assign lineState = {dpSync[1], dnSync[1]};
    assign se0 = lineState == 2'b00;

    // two bit times less two cycles, so two sample strobes have seen SE0 whatever the phase
    assign eopLimit = (usbRxPkg::ClksPerBit << 1) - 8'd3;

    assign dataP_o = dpSync[1];
    assign isValidDp_o = dpSync[1] != dnSync[1];  // J or K, not SE0 or SE1
    assign dataEdge_o = lineState != prevState;   // any change of J, K or SE0
    assign eopDetected_o = eopFlag;

    always_ff @(posedge clk48_i) begin
        if (reset_i) begin
            dpSync <= 2'b11;  // the bus idles in J, D+ high and D- low
            dnSync <= 2'b00;
            prevState <= 2'b10;
            se0Count <= 8'd0;
            eopFlag <= 1'b0;
        end else begin
            dpSync <= {dpSync[0], usbDp_i};
            dnSync <= {dnSync[0], usbDn_i};
            prevState <= lineState;

            if (!se0) begin
                se0Count <= 8'd0;
            end else if (se0Count != eopLimit + 8'd1) begin
                se0Count <= se0Count + 8'd1;  // saturates so the flag is raised once per SE0
            end

            if (se0 && se0Count == eopLimit) begin
                eopFlag <= 1'b1;
            end else if (ackEop_i) begin
                eopFlag <= 1'b0;  // controller has consumed the end-of-packet
            end
        end
    end

    // the controller may only acknowledge an end-of-packet that is actually pending
    ackOnlyWhenPending: assert property (@(posedge clk48_i) disable iff (reset_i)
        ackEop_i |-> eopDetected_o);

endmodule

// File: verilog/usbDpll.sv
`timescale 1ns/1ps

module usbDpll (
    input  logic clk48_i,
    input  logic reset_i,
    input  logic dataEdge_i,
    output logic sampleStrobe_o
);

    logic [7:0] phase;  // 48 MHz cycles since the last bit boundary

    // sample in the middle of the bit, two cycles past the boundary
    assign sampleStrobe_o = phase == (usbRxPkg::ClksPerBit >> 1);

    always_ff @(posedge clk48_i) begin
        if (reset_i) begin
            phase <= 8'd0;
        end else if (dataEdge_i) begin
            phase <= 8'd1;  // the edge cycle itself counts as phase zero
        end else if (phase == usbRxPkg::ClksPerBit - 8'd1) begin
            phase <= 8'd0;  // free-running between edges keeps long runs of J or K sampled
        end else begin
            phase <= phase + 8'd1;
        end
    end

    // realignment must never produce back-to-back samples of the same bit
    singleCycleStrobe: assert property (@(posedge clk48_i) disable iff (reset_i)
        sampleStrobe_o |=> !sampleStrobe_o);

endmodule

// File: verilog/usbCrc.sv
`timescale 1ns/1ps

module usbCrc (
    input  logic clk48_i,
    input  logic reset_i,
    input  logic crcInit_i,
    input  logic crcUse16_i,
    input  logic crcBit_i,
    input  logic crcBitValid_i,
    output logic crcOk_o
);

    logic [15:0] crcReg;    // CRC5 lives in the low five bits, upper bits then carry junk
    logic [15:0] poly;
    logic        feedback;

    // x^16+x^15+x^2+1 for data packets, x^5+x^2+1 for tokens
    assign poly = crcUse16_i ? 16'h8005 : 16'h0005;
    assign feedback = crcBit_i ^ (crcUse16_i ? crcReg[15] : crcReg[4]);

    assign crcOk_o = crcUse16_i ? crcReg == usbRxPkg::Crc16Residue
                                : crcReg[4:0] == usbRxPkg::Crc5Residue;

    always_ff @(posedge clk48_i) begin
        if (reset_i || crcInit_i) begin
            crcReg <= 16'hFFFF;  // USB seeds both CRCs with all ones
        end else if (crcBitValid_i) begin
            crcReg <= {crcReg[14:0], 1'b0} ^ (feedback ? poly : 16'h0000);
        end
    end

endmodule

// File: verilog/usbBitUnstuff.sv
`timescale 1ns/1ps

module usbBitUnstuff (
    input  logic clk48_i,
    input  logic reset_i,
    input  logic unstuffClear_i,
    input  logic bitValid_i,
    input  logic bitData_i,
    output logic dropBit_o,
    output logic stuffError_o
);

    logic [2:0] onesCount;  // length of the current run of ones
    logic       errFlag;
    logic       stuffSlot;  // this bit follows six ones and must be a stuffed zero

    assign stuffSlot = bitValid_i && onesCount == 3'd6;
    assign dropBit_o = stuffSlot;
    assign stuffError_o = errFlag || (stuffSlot && bitData_i);  // a seventh one is a violation

    always_ff @(posedge clk48_i) begin
        if (reset_i) begin
            onesCount <= 3'd0;
            errFlag <= 1'b0;
        end else if (unstuffClear_i) begin
            // stuffing starts with SYNC, whose closing one opens the first run
            onesCount <= {2'b00, bitValid_i && bitData_i};
            errFlag <= 1'b0;
        end else if (bitValid_i) begin
            if (stuffSlot) begin
                onesCount <= 3'd0;
                if (bitData_i) begin
                    errFlag <= 1'b1;  // held until the next SYNC
                end
            end else if (bitData_i) begin
                onesCount <= onesCount + 3'd1;
            end else begin
                onesCount <= 3'd0;
            end
        end
    end

endmodule

// File: verilog/usbRx.sv
`timescale 1ns/1ps

module usbRx (
    input  logic       clk48_i,
    input  logic       reset_i,
    input  logic       dataP_i,
    input  logic       isValidDp_i,
    input  logic       eopDetected_i,
    input  logic       sampleStrobe_i,
    output logic       ackEop_o,
    output logic       unstuffClear_o,
    output logic       bitValid_o,
    output logic       bitData_o,
    input  logic       dropBit_i,
    input  logic       stuffError_i,
    output logic       crcInit_o,
    output logic       crcUse16_o,
    output logic       crcBit_o,
    output logic       crcBitValid_o,
    input  logic       crcOk_i,
    input  logic       rxAcceptNewData_i,
    output logic       rxDataValid_o,
    output logic       rxIsLastByte_o,
    output logic       keepPacket_o,
    output logic [7:0] rxData_o
);

    logic       huntSync;   // looking for SYNC in the decoded stream
    logic       inPacket;   // between SYNC and end-of-packet, idle when neither is set
    logic       lastLevel;  // D+ level of the previous sample, for NRZI
    logic [7:0] syncShift;
    logic [7:0] syncNext;
    logic [7:0] dataShift;
    logic [7:0] byteNext;
    logic [2:0] bitCount;   // unstuffed bits since SYNC, modulo eight
    logic       syncFound;
    logic       takeBit;
    logic       byteDone;
    logic       eopDone;
    logic       gotPid;
    logic       moreBytes;  // something followed the PID
    logic       overflow;
    logic       pidOk;
    logic       typeOk;
    logic       keepNow;
    logic [7:0] pendByte;   // held back one byte so the last one can be flagged
    logic       pendValid;
    usbRxPkg::pidByte_u pidReg;

    logic [9:0] fifoMem [usbRxPkg::FifoDepth];  // {byte, last, keep}
    logic [$clog2(usbRxPkg::FifoDepth)-1:0] wrPtr;
    logic [$clog2(usbRxPkg::FifoDepth)-1:0] rdPtr;
    logic [7:0] fifoCount;
    logic       fifoFull;
    logic       push;
    logic       pushOk;
    logic       pop;

    assign bitValid_o = sampleStrobe_i && isValidDp_i;  // SE0 samples carry no bit
    assign bitData_o = dataP_i == lastLevel;            // no change on the line decodes as one
    assign syncNext = {bitData_o, syncShift[7:1]};
    assign byteNext = {bitData_o, dataShift[7:1]};      // bytes arrive LSB first

    assign syncFound = huntSync && bitValid_o && syncNext == usbRxPkg::SyncPattern;
    assign unstuffClear_o = syncFound;
    assign crcInit_o = syncFound;
    assign ackEop_o = eopDetected_i;  // a stray SE0 while idle is consumed as well

    assign eopDone = inPacket && eopDetected_i;
    assign takeBit = inPacket && bitValid_o && !dropBit_i && !eopDetected_i;
    assign byteDone = takeBit && bitCount == 3'd7;

    assign crcBit_o = bitData_o;
    assign crcBitValid_o = takeBit && gotPid;  // the PID is outside the CRC
    assign crcUse16_o = pidReg.fields.code inside {usbRxPkg::PidData0, usbRxPkg::PidData1};

    // keep decision, only sampled in the end-of-packet cycle
    always_comb begin
        pidOk = pidReg.fields.check == ~pidReg.fields.code;
        case (pidReg.fields.code)
            usbRxPkg::PidOut, usbRxPkg::PidIn, usbRxPkg::PidSof, usbRxPkg::PidSetup,
            usbRxPkg::PidData0, usbRxPkg::PidData1: typeOk = crcOk_i;
            usbRxPkg::PidAck, usbRxPkg::PidNak, usbRxPkg::PidStall: typeOk = !moreBytes;
            default: typeOk = 1'b0;  // reserved codes are never kept
        endcase
        keepNow = gotPid && pidOk && typeOk && !stuffError_i && bitCount == 3'd0 && !overflow;
    end

    assign fifoFull = fifoCount == usbRxPkg::FifoDepth;
    assign rxDataValid_o = fifoCount != 8'd0;
    assign pop = rxDataValid_o && rxAcceptNewData_i;
    assign push = pendValid && (byteDone || eopDone);  // pending byte leaves when its successor is known
    assign pushOk = push && (!fifoFull || pop);        // a pop in the same cycle frees the slot
    assign {rxData_o, rxIsLastByte_o, keepPacket_o} = fifoMem[rdPtr];

    always_ff @(posedge clk48_i) begin
        if (takeBit) begin
            dataShift <= byteNext;
        end
        if (byteDone) begin
            pendByte <= byteNext;
        end
        if (byteDone && !gotPid) begin
            pidReg.raw <= byteNext;
        end
        if (pushOk) begin
            fifoMem[wrPtr] <= {pendByte, eopDone, eopDone && keepNow};
        end
    end

    always_ff @(posedge clk48_i) begin
        if (reset_i) begin
            huntSync <= 1'b0;
            inPacket <= 1'b0;
            lastLevel <= 1'b1;
            syncShift <= 8'hFF;
            bitCount <= 3'd0;
            gotPid <= 1'b0;
            moreBytes <= 1'b0;
            overflow <= 1'b0;
            pendValid <= 1'b0;
            wrPtr <= '0;
            rdPtr <= '0;
            fifoCount <= 8'd0;
        end else begin
            if (bitValid_o) begin
                lastLevel <= dataP_i;
                syncShift <= syncNext;
            end
            if (!huntSync && !inPacket && bitValid_o && !bitData_o) begin
                huntSync <= 1'b1;  // first K after idle J starts the SYNC
            end
            if (syncFound) begin
                huntSync <= 1'b0;
                inPacket <= 1'b1;
                bitCount <= 3'd0;
                gotPid <= 1'b0;
                moreBytes <= 1'b0;
                overflow <= 1'b0;
                pendValid <= 1'b0;
            end
            if (takeBit) begin
                bitCount <= bitCount + 3'd1;
            end
            if (byteDone) begin
                pendValid <= 1'b1;
                gotPid <= 1'b1;
                moreBytes <= gotPid;
            end
            if (eopDetected_i) begin
                huntSync <= 1'b0;
                inPacket <= 1'b0;
                pendValid <= 1'b0;
                lastLevel <= 1'b1;   // J follows the EOP and must decode as idle
                syncShift <= 8'hFF;  // so packet tail bits cannot fake the next SYNC
            end
            if (push && !pushOk) begin
                overflow <= 1'b1;  // byte lost, packet can no longer be kept
            end
            if (pushOk) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            fifoCount <= fifoCount + {7'd0, pushOk} - {7'd0, pop};
        end
    end

    // pointer bookkeeping must agree that an entry is there to pop
    popHasEntry: assert property (@(posedge clk48_i) disable iff (reset_i)
        pop |-> (wrPtr != rdPtr || fifoFull));

    // the backend sees the same entry until it accepts it
    holdUntilAccepted: assert property (@(posedge clk48_i) disable iff (reset_i)
        rxDataValid_o && !rxAcceptNewData_i |=>
            rxDataValid_o && $stable({rxData_o, rxIsLastByte_o, keepPacket_o}));

endmodule

// File: verilog/usbRxTop.sv
`timescale 1ns/1ps

module usbRxTop (
    input  logic       clk48_i,
    input  logic       reset_i,
    input  logic       usbDp_i,
    input  logic       usbDn_i,
    input  logic       rxAcceptNewData_i,
    output logic       rxDataValid_o,
    output logic       rxIsLastByte_o,
    output logic       keepPacket_o,
    output logic [7:0] rxData_o
);

    logic dataP;
    logic dataEdge;
    logic isValidDp;
    logic eopDetected;
    logic ackEop;
    logic sampleStrobe;
    logic unstuffClear;
    logic bitValid;
    logic bitData;
    logic dropBit;
    logic stuffError;
    logic crcInit;
    logic crcUse16;
    logic crcBit;
    logic crcBitValid;
    logic crcOk;

    usbSerialFrontend frontend (
        .clk48_i(clk48_i),
        .reset_i(reset_i),
        .usbDp_i(usbDp_i),
        .usbDn_i(usbDn_i),
        .dataP_o(dataP),
        .dataEdge_o(dataEdge),
        .isValidDp_o(isValidDp),
        .eopDetected_o(eopDetected),
        .ackEop_i(ackEop)
    );

    usbDpll dpll (
        .clk48_i(clk48_i),
        .reset_i(reset_i),
        .dataEdge_i(dataEdge),
        .sampleStrobe_o(sampleStrobe)
    );

    usbCrc crcEngine (
        .clk48_i(clk48_i),
        .reset_i(reset_i),
        .crcInit_i(crcInit),
        .crcUse16_i(crcUse16),
        .crcBit_i(crcBit),
        .crcBitValid_i(crcBitValid),
        .crcOk_o(crcOk)
    );

    usbBitUnstuff unstuff (
        .clk48_i(clk48_i),
        .reset_i(reset_i),
        .unstuffClear_i(unstuffClear),
        .bitValid_i(bitValid),
        .bitData_i(bitData),
        .dropBit_o(dropBit),
        .stuffError_o(stuffError)
    );

    usbRx rx (
        .clk48_i(clk48_i),
        .reset_i(reset_i),
        .dataP_i(dataP),
        .isValidDp_i(isValidDp),
        .eopDetected_i(eopDetected),
        .sampleStrobe_i(sampleStrobe),
        .ackEop_o(ackEop),
        .unstuffClear_o(unstuffClear),
        .bitValid_o(bitValid),
        .bitData_o(bitData),
        .dropBit_i(dropBit),
        .stuffError_i(stuffError),
        .crcInit_o(crcInit),
        .crcUse16_o(crcUse16),
        .crcBit_o(crcBit),
        .crcBitValid_o(crcBitValid),
        .crcOk_i(crcOk),
        .rxAcceptNewData_i(rxAcceptNewData_i),
        .rxDataValid_o(rxDataValid_o),
        .rxIsLastByte_o(rxIsLastByte_o),
        .keepPacket_o(keepPacket_o),
        .rxData_o(rxData_o)
    );

endmodule

// File: bench/usbRxClockGen.sv
`timescale 1ns/1ps

module usbRxClockGen (
    output logic clk_o,
    output logic reset_o
);

    // 20 ns period, stands in for the 48 MHz sampling clock in cycle terms
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clk_o);
        #2 reset_o = 1'b0;  // released just after the third rising edge
    end

endmodule

// File: bench/usbRxTb.sv
`timescale 1ns/1ps

module usbRxTb;

    logic        clk;
    logic        reset;
    logic        usbDp;
    logic        usbDn;
    logic        rxAccept;
    logic        rxDataValid;
    logic        rxIsLastByte;
    logic        keepPacket;
    logic [7:0]  rxData;

    logic [7:0]  txBytes[$];   // packet being built, PID first, CRC bytes last
    logic [7:0]  expData[$];   // bytes the backend must see, in order
    int          pktLen[$];
    logic        pktKeep[$];
    bit          pktExact[$];  // cleared when a stuffing error makes the bytes unpredictable
    int          byteIndex;    // position inside the packet the monitor is on
    logic [31:0] rngState;
    logic [31:0] bpState;
    bit          randomAccept;
    int          lowLeft;
    int          highLeft;

    usbRxClockGen clockGen (
        .clk_o(clk),
        .reset_o(reset)
    );

    usbRxTop UUT (
        .clk48_i(clk),
        .reset_i(reset),
        .usbDp_i(usbDp),
        .usbDn_i(usbDn),
        .rxAcceptNewData_i(rxAccept),
        .rxDataValid_o(rxDataValid),
        .rxIsLastByte_o(rxIsLastByte),
        .keepPacket_o(keepPacket),
        .rxData_o(rxData)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compareByte(input string name, input logic [7:0] want, input logic [7:0] got);
        if (got !== want) begin
            abortRun($sformatf("FAILED at %0t: %s expected %h got %h", $time, name, want, got));
        end
    endtask

    task automatic compareFlag(input string name, input logic want, input logic got);
        if (got !== want) begin
            abortRun($sformatf("FAILED at %0t: %s expected %b got %b", $time, name, want, got));
        end
    endtask

    task automatic comparePid(input string name, input usbRxPkg::pidByte_u want,
                              input usbRxPkg::pidByte_u got);
        if (got.raw !== want.raw) begin
            abortRun($sformatf("FAILED at %0t: %s expected %h got %h", $time, name,
                               want.raw, got.raw));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // bit i of the packet after SYNC, each byte LSB first
    function automatic logic wireBit(input int i);
        return txBytes[i / 8][i % 8];
    endfunction

    function automatic logic [4:0] crc5Over(input int first, input int count);
        logic [4:0] crc;
        int i;
        crc = 5'h1F;
        for (i = first; i < first + count; i++) begin
            crc = {crc[3:0], 1'b0} ^ ((wireBit(i) ^ crc[4]) ? 5'b00101 : 5'b00000);  // x^5+x^2+1
        end
        return crc;
    endfunction

    function automatic logic [15:0] crc16Over(input int first, input int count);
        logic [15:0] crc;
        int i;
        crc = 16'hFFFF;
        for (i = first; i < first + count; i++) begin
            crc = {crc[14:0], 1'b0} ^ ((wireBit(i) ^ crc[15]) ? 16'h8005 : 16'h0000);
        end
        return crc;
    endfunction

    // true when an unstuffed stream carries six ones followed by another bit
    function automatic bit stuffViolation(input bit stuffOn);
        int ones;
        int i;
        if (stuffOn) begin
            return 1'b0;
        end
        ones = 1;  // SYNC closes with a one
        for (i = 0; i < txBytes.size() * 8; i++) begin
            if (ones == 6) begin
                return 1'b1;  // receiver takes this slot for a stuffed zero
            end
            ones = wireBit(i) ? ones + 1 : 0;
        end
        return 1'b0;
    endfunction

    // keep flag the backend should see with the last byte of txBytes
    function automatic logic expectPacket(input bit stuffOn);
        usbRxPkg::pidByte_u pid;
        int bits;
        pid.raw = txBytes[0];
        bits = (txBytes.size() - 1) * 8;  // everything after the PID goes through the CRC
        if (stuffViolation(stuffOn) || pid.fields.check != ~pid.fields.code) begin
            return 1'b0;
        end
        case (pid.fields.code)
            usbRxPkg::PidOut, usbRxPkg::PidIn, usbRxPkg::PidSof, usbRxPkg::PidSetup:
                return crc5Over(8, bits) == usbRxPkg::Crc5Residue;
            usbRxPkg::PidData0, usbRxPkg::PidData1:
                return crc16Over(8, bits) == usbRxPkg::Crc16Residue;
            usbRxPkg::PidAck, usbRxPkg::PidNak, usbRxPkg::PidStall:
                return bits == 0;  // handshakes are the PID alone
            default:
                return 1'b0;
        endcase
    endfunction

    task automatic startPacket(input usbRxPkg::pidCode_e code);
        usbRxPkg::pidByte_u pid;
        pid.fields.code = code;
        pid.fields.check = ~code;
        txBytes.delete();
        txBytes.push_back(pid.raw);
    endtask

    task automatic addPayload(input int n);
        logic [31:0] r;
        int i;
        for (i = 0; i < n; i++) begin
            r = nextRandom();
            txBytes.push_back(r[7:0]);
        end
    endtask

    task automatic appendCrc16();
        logic [15:0] crc;
        logic [7:0] first;
        logic [7:0] second;
        int i;
        crc = ~crc16Over(8, (txBytes.size() - 1) * 8);  // sent inverted, high bit first
        for (i = 0; i < 8; i++) begin
            first[i] = crc[15 - i];
            second[i] = crc[7 - i];
        end
        txBytes.push_back(first);
        txBytes.push_back(second);
    endtask

    task automatic appendToken(input logic [6:0] addr, input logic [3:0] endp);
        logic [15:0] field;
        logic [4:0] crc;
        int i;
        field = {5'b00000, endp, addr};
        txBytes.push_back(field[7:0]);
        txBytes.push_back(field[15:8]);
        crc = ~crc5Over(8, 11);
        for (i = 0; i < 5; i++) begin
            field[11 + i] = crc[4 - i];
        end
        txBytes[2] = field[15:8];  // CRC5 fills the top five bits of the second byte
    endtask

    task automatic driveSymbol(input logic dp, input logic dn);
        @(posedge clk);
        #2;
        usbDp = dp;
        usbDn = dn;
        repeat (usbRxPkg::ClksPerBit - 1) @(posedge clk);
    endtask

    // SYNC, payload with stuffing, NRZI, then SE0 for two bits and J
    task automatic sendPacket(input bit stuffOn);
        logic level;
        logic b;
        int ones;
        int i;
        level = 1'b1;  // idle J
        ones = 0;
        for (i = 0; i < 8 + txBytes.size() * 8; i++) begin
            b = (i < 8) ? usbRxPkg::SyncPattern[i] : wireBit(i - 8);
            if (!b) begin
                level = ~level;  // a zero is a transition
            end
            driveSymbol(level, ~level);
            ones = b ? ones + 1 : 0;
            if (stuffOn && ones == 6) begin
                level = ~level;
                driveSymbol(level, ~level);
                ones = 0;
            end
        end
        driveSymbol(1'b0, 1'b0);
        driveSymbol(1'b0, 1'b0);
        driveSymbol(1'b1, 1'b0);
        driveSymbol(1'b1, 1'b0);
    endtask

    task automatic sendChecked(input bit stuffOn);
        int i;
        pktKeep.push_back(expectPacket(stuffOn));
        pktExact.push_back(!stuffViolation(stuffOn));
        pktLen.push_back(txBytes.size());
        if (!stuffViolation(stuffOn)) begin
            for (i = 0; i < txBytes.size(); i++) begin
                expData.push_back(txBytes[i]);
            end
        end
        sendPacket(stuffOn);
    endtask

    task automatic sendRandomPacket();
        logic [31:0] r;
        r = nextRandom();
        case (r[1:0])
            2'd0: begin
                startPacket(usbRxPkg::PidData0);
                addPayload(r[5:2] % 9);
                appendCrc16();
            end
            2'd1: begin
                startPacket(usbRxPkg::PidData1);
                addPayload(r[5:2] % 9);
                appendCrc16();
            end
            2'd2: begin
                startPacket(r[2] ? usbRxPkg::PidOut : usbRxPkg::PidSetup);
                appendToken(r[9:3], r[13:10]);
            end
            default: startPacket(usbRxPkg::PidNak);
        endcase
        sendChecked(1'b1);
    endtask

    task automatic finishPacket();
        compareFlag("keepPacket_o", pktKeep.pop_front(), keepPacket);
        void'(pktLen.pop_front());
        void'(pktExact.pop_front());
        byteIndex = 0;
    endtask

    task automatic collectByte();
        usbRxPkg::pidByte_u wantPid;
        usbRxPkg::pidByte_u seenPid;
        logic [7:0] want;
        logic wantLast;
        if (pktLen.size() == 0) begin
            abortRun("a byte was delivered while no packet was outstanding");
        end else if (pktExact[0]) begin
            want = expData.pop_front();
            if (byteIndex == 0) begin
                wantPid.raw = want;
                seenPid.raw = rxData;
                comparePid("rxData_o", wantPid, seenPid);
            end else begin
                compareByte("rxData_o", want, rxData);
            end
            byteIndex++;
            wantLast = byteIndex == pktLen[0];
            compareFlag("rxIsLastByte_o", wantLast, rxIsLastByte);
            if (wantLast) begin
                finishPacket();
            end
        end else begin
            byteIndex++;  // damaged packet, only its end and keep flag are predictable
            if (rxIsLastByte) begin
                finishPacket();
            end else if (byteIndex > 64) begin
                abortRun("a damaged packet never delivered its last byte");
            end
        end
    endtask

    // the line carries no packet, so the DUT must present no byte
    task automatic checkIdleOutput(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            compareFlag("rxDataValid_o", 1'b0, rxDataValid);
        end
    endtask

    task automatic waitReset();
        int n;
        n = 0;
        while (reset) begin
            @(posedge clk);
            n++;
            if (n > 20) begin
                abortRun("timeout waiting for reset to be released");
            end
        end
    endtask

    task automatic waitDrain();
        int n;
        n = 0;
        while (pktLen.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > 4000) begin
                abortRun("timeout waiting for the backend to receive every packet");
            end
        end
    endtask

    // outputs are sampled on the edge, before the DUT registers update
    always @(posedge clk) begin
        if (!reset && rxDataValid && rxAccept) begin
            collectByte();
        end
    end

    // backend accept, either always ready or stalled for up to 16 cycles at a time
    initial begin
        rxAccept = 1'b0;
        bpState = xorshift(32'h4d7b5272);
        lowLeft = 0;
        highLeft = 0;
        forever begin
            @(posedge clk);
            #2;
            if (!randomAccept) begin
                rxAccept = 1'b1;
            end else if (lowLeft > 0) begin
                rxAccept = 1'b0;
                lowLeft--;
            end else if (highLeft > 0) begin
                rxAccept = 1'b1;
                highLeft--;
            end else begin
                bpState = xorshift(bpState);
                lowLeft = bpState % 17;
                highLeft = 1 + (bpState >> 8) % 4;
                rxAccept = 1'b1;
            end
        end
    end

    initial begin
        usbDp = 1'b1;  // J on the bus from time zero
        usbDn = 1'b0;
        rngState = 32'h4d7b5272;
        randomAccept = 1'b0;
        byteIndex = 0;
        waitReset();

        // idle J after reset must not produce a byte
        checkIdleOutput(40);

        startPacket(usbRxPkg::PidData0);
        addPayload(8);
        appendCrc16();
        sendChecked(1'b1);
        startPacket(usbRxPkg::PidIn);
        appendToken(7'h3A, 4'h5);
        sendChecked(1'b1);
        startPacket(usbRxPkg::PidAck);
        sendChecked(1'b1);
        waitDrain();

        startPacket(usbRxPkg::PidData1);
        addPayload(5);
        appendCrc16();
        txBytes[txBytes.size() - 1] = txBytes[txBytes.size() - 1] ^ 8'h08;  // one CRC bit wrong
        sendChecked(1'b1);
        startPacket(usbRxPkg::PidData0);
        addPayload(3);
        appendCrc16();
        txBytes[0] = txBytes[0] ^ 8'h40;  // check nibble no longer the complement
        sendChecked(1'b1);

        // sixteen ones sent without stuffing, then the same kind of run stuffed properly
        startPacket(usbRxPkg::PidData0);
        txBytes.push_back(8'hFF);
        txBytes.push_back(8'hFF);
        appendCrc16();
        sendChecked(1'b0);
        startPacket(usbRxPkg::PidData1);
        txBytes.push_back(8'hFF);
        txBytes.push_back(8'hFF);
        txBytes.push_back(8'h7E);
        txBytes.push_back(8'h3F);
        appendCrc16();
        sendChecked(1'b1);
        waitDrain();

        randomAccept = 1'b1;
        repeat (8) begin
            sendRandomPacket();
        end
        waitDrain();
        randomAccept = 1'b0;

        // a repeated or extra byte after the last packet would still show up as valid
        checkIdleOutput(64);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: compile.f
verilog/usbRxPkg.sv
verilog/usbSerialFrontend.sv
verilog/usbDpll.sv
verilog/usbCrc.sv
verilog/usbBitUnstuff.sv
verilog/usbRx.sv
verilog/usbRxTop.sv
bench/usbRxClockGen.sv
bench/usbRxTb.sv

// File: Bender.yml
package:
  name: usbRx

sources:
  - verilog/usbRxPkg.sv
  - verilog/usbSerialFrontend.sv
  - verilog/usbDpll.sv
  - verilog/usbCrc.sv
  - verilog/usbBitUnstuff.sv
  - verilog/usbRx.sv
  - verilog/usbRxTop.sv
  - target: simulation
    files:
      - bench/usbRxClockGen.sv
      - bench/usbRxTb.sv
